// ==== dv/usb_dump_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "usb_dump_cfg.svh"

module usb_dump_tb;
    import usb_dump_pkg::*;

    localparam int CLK_NS      = 20;
    localparam int LINE_CHARS  = `USB_DUMP_BYTES_PER_LINE * 3 + 1;
    localparam int BOOT_CHARS  = 11 + `USB_DUMP_BOOT_LINES * LINE_CHARS + 1;
    localparam int USER_CHARS  = 5 + 3 + 1 + `USB_DUMP_USER_LINES * LINE_CHARS + 1;
    localparam int CHAR_CYCLES = 24;  // sequencer and port overhead plus a stall of up to 8
    localparam int FILL_CYCLES = 1 << `USB_DUMP_BIT_ADDR_W;
    localparam int RUN_CYCLES  = FILL_CYCLES + (4 * BOOT_CHARS + USER_CHARS) * CHAR_CYCLES
                                 + 2000;

    logic       MCLK = 1'b0;
    logic       reset;
    logic       buf_wr_en;
    bit_addr_t  buf_wr_addr;
    logic       buf_wr_bit;
    logic       send_boot;
    logic       send_user;
    page_t      page;
    logic       fifo_txe_n;
    ascii_t     fifo_data;
    logic       fifo_wr_n;

    logic [15:0] lfsr_q = 16'd63;
    ascii_t      model_mem [1 << `USB_DUMP_BYTE_ADDR_W];  // local copy of the page buffer
    ascii_t      exp_q [$];                               // expected character stream
    int          val_errs = 0;
    int          other_errs = 0;
    int          strobe_cnt = 0;
    int          low_cnt = 0;
    ascii_t      held_data;
    logic        prev_wr_n = 1'b1;
    logic        prev_txe_n = 1'b1;
    logic        stall_en = 1'b0;
    logic        txe_hold = 1'b0;
    logic        txe_next;
    int          stall_left;
    page_t       page_a;
    page_t       page_b;

    usb_dump_top dut_i (.*);

    initial begin
        forever #(CLK_NS / 2) MCLK = ~MCLK;
    end

    initial begin
        #(RUN_CYCLES * CLK_NS);
        $display("Watchdog expired after %0d cycles, the run did not complete", RUN_CYCLES);
        $display("SIMULATION FAILED");
        $finish;
    end

    // 16 bit Fibonacci LFSR, taps 16 14 13 11
    function automatic logic next_bit();
        logic fb;
        fb = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
        lfsr_q = {lfsr_q[14:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        int          i;
        v = '0;
        for (i = 0; i < n; i++)
            v = {v[30:0], next_bit()};
        return v;
    endfunction

    function automatic ascii_t hex_char(input logic [3:0] n);
        return (n < 4'd10) ? ascii_t'(8'h30 + n) : ascii_t'(8'h37 + n);  // "A" is 0x37 + 10
    endfunction

    task automatic step_cycle;
        @(posedge MCLK);
        #2;
    endtask

    task automatic fill_buffer;
        int   a;
        logic b;
        for (a = 0; a < FILL_CYCLES; a++) begin
            step_cycle;
            b           = next_bit();
            buf_wr_en   = 1'b1;
            buf_wr_addr = bit_addr_t'(a);
            buf_wr_bit  = b;
            model_mem[a / 8][a % 8] = b;  // bit 8n+k is bit k of byte n
        end
        step_cycle;
        buf_wr_en = 1'b0;
    endtask

    task automatic build_frame(input logic boot, input page_t pg);
        string  title;
        int     lines;
        int     l;
        int     c;
        ascii_t d;
        title = boot ? "BOOT DUMP: " : "PAGE ";
        lines = boot ? `USB_DUMP_BOOT_LINES : `USB_DUMP_USER_LINES;
        for (c = 0; c < title.len(); c++)
            exp_q.push_back(ascii_t'(title[c]));
        if (!boot) begin
            for (c = 2; c >= 0; c--)
                exp_q.push_back(hex_char(pg[4*c +: 4]));
            exp_q.push_back(8'd13);
        end
        for (l = 0; l < lines; l++) begin
            for (c = 0; c < `USB_DUMP_BYTES_PER_LINE; c++) begin
                d = model_mem[l * `USB_DUMP_BYTES_PER_LINE + c];
                exp_q.push_back(hex_char(d[7:4]));
                exp_q.push_back(hex_char(d[3:0]));
                exp_q.push_back(8'h20);
            end
            exp_q.push_back(8'd13);
        end
        exp_q.push_back(8'd13);  // closing line end
    endtask

    task automatic wait_frame_done;
        int   n;
        logic done;
        n    = 0;
        done = 1'b0;
        while (!done && n < BOOT_CHARS * CHAR_CYCLES) begin
            @(negedge MCLK);
            done = (dut_i.dump_sequencer_i.state == ST_DONE) && dut_i.char_ready && fifo_wr_n;
            n++;
        end
        assert (done) else begin
            other_errs++;
            $display("Frame did not finish within %0d cycles, sequencer in %s", n,
                     dut_i.dump_sequencer_i.state.name());
        end
    endtask

    task automatic run_frame(input logic boot_req, input logic user_req, input page_t pg);
        int held;
        build_frame(boot_req, pg);  // boot wins when both are high
        step_cycle;
        page      = pg;
        send_boot = boot_req;
        send_user = user_req;
        wait_frame_done;
        assert (exp_q.size() == 0) else begin
            other_errs++;
            $display("Frame ended with %0d expected characters never sent", exp_q.size());
        end
        exp_q.delete();
        held = strobe_cnt;
        repeat (40) step_cycle;  // request still held after done
        assert (strobe_cnt == held) else begin
            other_errs++;
            $display("Characters were sent after the frame completed with the request held");
        end
        send_boot = 1'b0;
        send_user = 1'b0;
        repeat (3) step_cycle;
    endtask

    task automatic abort_frame;
        int n;
        int held;
        build_frame(1'b1, '0);
        step_cycle;
        send_boot = 1'b1;
        n    = 0;
        held = strobe_cnt + 6;
        while (strobe_cnt < held && n < 500) begin
            step_cycle;
            n++;
        end
        assert (strobe_cnt >= held) else begin
            other_errs++;
            $display("The frame before the abort did not start within %0d cycles", n);
        end
        txe_hold = 1'b1;
        repeat (10) step_cycle;
        assert (!dut_i.char_ready && fifo_wr_n) else begin
            other_errs++;
            $display("The port was not waiting on transmit-empty when the requests dropped");
        end
        held      = strobe_cnt;
        send_boot = 1'b0;  // drop while the port waits on transmit-empty
        repeat (10) step_cycle;
        exp_q.delete();
        txe_hold = 1'b0;
        repeat (30) step_cycle;
        assert (strobe_cnt == held && dut_i.dump_sequencer_i.state == ST_IDLE) else begin
            other_errs++;
            $display("Abort did not stop the frame, a strobe followed or the sequencer is busy");
        end
    endtask

    // transmit-empty: low when free, random high runs of 0..7 cycles when stalling
    initial begin
        fifo_txe_n = 1'b0;
        stall_left = 0;
        forever begin
            @(posedge MCLK);  // control flags are settled at the edge
            if (txe_hold) begin
                txe_next = 1'b1;
            end else if (!stall_en) begin
                txe_next = 1'b0;
            end else if (stall_left > 0) begin
                txe_next = 1'b1;
                stall_left--;
            end else begin
                txe_next   = 1'b0;
                stall_left = int'(rand_bits(3));
            end
            #2;
            fifo_txe_n = txe_next;
        end
    end

    // monitor at the falling edge, away from the edge where outputs change
    always @(negedge MCLK) begin
        if (!fifo_wr_n && prev_wr_n) begin
            strobe_cnt++;
            low_cnt   = 1;
            held_data = fifo_data;
            assert (!prev_txe_n) else begin
                other_errs++;
                $display("Strobe at %0t started without transmit-empty sampled low", $time);
            end
            assert (exp_q.size() != 0) else begin
                other_errs++;
                $display("Character %02h was sent at %0t when none was expected", fifo_data,
                         $time);
            end
            if (exp_q.size() != 0) begin
                assert (fifo_data == exp_q[0]) else begin
                    val_errs++;
                    $display("Fail at %0t: character %0d is %02h, expected %02h", $time,
                             strobe_cnt, fifo_data, exp_q[0]);
                end
                void'(exp_q.pop_front());
            end
        end else if (!fifo_wr_n) begin
            low_cnt++;
            assert (fifo_data == held_data) else begin
                val_errs++;
                $display("Fail at %0t: fifo_data moved from %02h to %02h in a strobe", $time,
                         held_data, fifo_data);
            end
        end else if (!prev_wr_n) begin
            assert (low_cnt == 2) else begin
                val_errs++;
                $display("Fail at %0t: strobe lasted %0d cycles, expected 2", $time, low_cnt);
            end
        end
        prev_wr_n  = fifo_wr_n;
        prev_txe_n = fifo_txe_n;
    end

    initial begin
        reset       = 1'b1;
        buf_wr_en   = 1'b0;
        buf_wr_addr = '0;
        buf_wr_bit  = 1'b0;
        send_boot   = 1'b0;
        send_user   = 1'b0;
        page        = '0;
        repeat (3) @(posedge MCLK);
        #2;
        reset = 1'b0;
        fill_buffer;  // thousands of idle cycles with no request
        page_a = page_t'(rand_bits(`USB_DUMP_PAGE_W));
        page_b = page_t'(rand_bits(`USB_DUMP_PAGE_W));
        assert (strobe_cnt == 0 && fifo_wr_n) else begin
            other_errs++;
            $display("A strobe appeared before any request was made");
        end
        run_frame(1'b1, 1'b0, page_a);
        stall_en = 1'b1;
        run_frame(1'b0, 1'b1, page_a);
        run_frame(1'b1, 1'b1, page_b);
        stall_en = 1'b0;
        abort_frame;
        run_frame(1'b1, 1'b0, page_b);  // restart after abort from the first title character
        $display("Run complete: %0d value errors, %0d other errors, %0d characters seen",
                 val_errs, other_errs, strobe_cnt);
        if (val_errs == 0 && other_errs == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== include/usb_dump_cfg.svh ====
`ifndef USB_DUMP_CFG_SVH
`define USB_DUMP_CFG_SVH

// page buffer geometry, 8192 bits seen as 1024 bytes
`define USB_DUMP_BIT_ADDR_W      13
`define USB_DUMP_BYTE_ADDR_W     10
`define USB_DUMP_ROM_ADDR_W      7
`define USB_DUMP_PAGE_W          12

// dump layout
`define USB_DUMP_BYTES_PER_LINE  16
`define USB_DUMP_BOOT_LINES      30
`define USB_DUMP_USER_LINES      8

// text rom map, hex digits sit at 0..15
`define USB_DUMP_BOOT_BASE       16
`define USB_DUMP_USER_BASE       80

// title texts
`define USB_DUMP_BOOT_TITLE      "BOOT DUMP: "
`define USB_DUMP_BOOT_LEN        11
`define USB_DUMP_USER_TITLE      "PAGE "
`define USB_DUMP_USER_LEN        5

// character codes
`define USB_DUMP_EOL             8'd13
`define USB_DUMP_SPACE           8'h20

`endif

// ==== src/dump_sequencer.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "usb_dump_cfg.svh"

module dump_sequencer (
    input  wire                           MCLK,
    input  wire                           reset,
    input  wire                           send_boot,
    input  wire                           send_user,
    input  wire usb_dump_pkg::page_t      page,
    output logic                          buf_rd_en,
    output usb_dump_pkg::byte_addr_t      buf_rd_addr,
    input  wire usb_dump_pkg::ascii_t     buf_rd_data,
    output logic                          rom_rd_en,
    output usb_dump_pkg::rom_addr_t       rom_addr,
    input  wire usb_dump_pkg::ascii_t     rom_data,
    output logic                          char_valid,
    output usb_dump_pkg::ascii_t          char_data,
    output logic                          char_abort,
    input  wire                           char_ready
);
    import usb_dump_pkg::*;

    localparam int TITLE_W = 4;
    localparam int LINE_W  = 5;
    localparam int COL_W   = $clog2(`USB_DUMP_BYTES_PER_LINE);
    localparam int DIGITS  = `USB_DUMP_PAGE_W / 4;

    seq_state_t         state;
    seq_state_t         ret_state;  // where SEND goes after the handshake
    logic               is_boot;
    page_t              page_q;     // shifted left one digit per character
    rom_addr_t          title_addr;
    logic [TITLE_W-1:0] title_cnt;  // characters left in the title, minus one
    logic [1:0]         digit_cnt;
    byte_addr_t         buf_addr;
    logic [COL_W-1:0]   col_cnt;
    logic [LINE_W-1:0]  line_cnt;
    logic               col_last;
    logic               line_last;

    assign char_abort = !send_boot && !send_user;
    assign char_valid = (state == ST_SEND) && !char_abort;

    assign col_last  = (col_cnt == COL_W'(`USB_DUMP_BYTES_PER_LINE - 1));
    assign line_last = is_boot ? (line_cnt == LINE_W'(`USB_DUMP_BOOT_LINES - 1))
                               : (line_cnt == LINE_W'(`USB_DUMP_USER_LINES - 1));

    assign buf_rd_en   = (state == ST_BYTE_RD);
    assign buf_rd_addr = buf_addr;

    assign rom_rd_en = (state == ST_TITLE_RD) || (state == ST_PAGE_RD) ||
                       (state == ST_HI_RD) || (state == ST_LO_RD);

    // buffer byte stays on buf_rd_data for both nibble lookups
    always_comb begin
        case (state)
            ST_PAGE_RD: rom_addr = rom_addr_t'(page_q[`USB_DUMP_PAGE_W-1 -: 4]);
            ST_HI_RD:   rom_addr = rom_addr_t'(buf_rd_data[7:4]);
            ST_LO_RD:   rom_addr = rom_addr_t'(buf_rd_data[3:0]);
            default:    rom_addr = title_addr;
        endcase
    end

    always_ff @(posedge MCLK) begin
        if (reset) begin
            state      <= ST_IDLE;
            ret_state  <= ST_IDLE;
            is_boot    <= 1'b0;
            page_q     <= '0;
            title_addr <= '0;
            title_cnt  <= '0;
            digit_cnt  <= '0;
            buf_addr   <= '0;
            col_cnt    <= '0;
            line_cnt   <= '0;
        end else if (char_abort) begin
            state <= ST_IDLE;  // both requests gone
        end else begin
            case (state)
                ST_IDLE: begin
                    // no abort, so at least one request is up; boot wins
                    is_boot   <= send_boot;
                    page_q    <= page;
                    digit_cnt <= '0;
                    buf_addr  <= '0;
                    col_cnt   <= '0;
                    line_cnt  <= '0;
                    if (send_boot) begin
                        title_addr <= rom_addr_t'(`USB_DUMP_BOOT_BASE);
                        title_cnt  <= TITLE_W'(`USB_DUMP_BOOT_LEN - 1);
                    end else begin
                        title_addr <= rom_addr_t'(`USB_DUMP_USER_BASE);
                        title_cnt  <= TITLE_W'(`USB_DUMP_USER_LEN - 1);
                    end
                    state <= ST_TITLE_RD;
                end
                ST_TITLE_RD: state <= ST_TITLE_LD;
                ST_TITLE_LD: begin
                    ret_state <= ST_TITLE_NEXT;
                    state     <= ST_SEND;
                end
                ST_TITLE_NEXT: begin
                    title_addr <= title_addr + 1'b1;
                    title_cnt  <= title_cnt - 1'b1;
                    if (title_cnt != '0) begin
                        state <= ST_TITLE_RD;
                    end else if (is_boot) begin
                        state <= ST_BYTE_RD;
                    end else begin
                        state <= ST_PAGE_RD;  // user frame prints the page first
                    end
                end
                ST_PAGE_RD: state <= ST_PAGE_LD;
                ST_PAGE_LD: begin
                    ret_state <= ST_PAGE_NEXT;
                    state     <= ST_SEND;
                end
                ST_PAGE_NEXT: begin
                    page_q    <= page_q << 4;
                    digit_cnt <= digit_cnt + 1'b1;
                    if (digit_cnt == 2'(DIGITS - 1)) begin
                        state <= ST_HDR_EOL;
                    end else begin
                        state <= ST_PAGE_RD;
                    end
                end
                ST_HDR_EOL: begin
                    ret_state <= ST_BYTE_RD;
                    state     <= ST_SEND;
                end
                ST_BYTE_RD: state <= ST_HI_RD;
                ST_HI_RD:   state <= ST_HI_LD;
                ST_HI_LD: begin
                    ret_state <= ST_LO_RD;
                    state     <= ST_SEND;
                end
                ST_LO_RD: state <= ST_LO_LD;
                ST_LO_LD: begin
                    ret_state <= ST_SPACE;
                    state     <= ST_SEND;
                end
                ST_SPACE: begin
                    ret_state <= ST_BYTE_NEXT;
                    state     <= ST_SEND;
                end
                ST_BYTE_NEXT: begin
                    buf_addr <= buf_addr + 1'b1;
                    if (col_last) begin
                        col_cnt <= '0;
                        state   <= ST_LINE_EOL;
                    end else begin
                        col_cnt <= col_cnt + 1'b1;
                        state   <= ST_BYTE_RD;
                    end
                end
                ST_LINE_EOL: begin
                    ret_state <= ST_LINE_NEXT;
                    state     <= ST_SEND;
                end
                ST_LINE_NEXT: begin
                    line_cnt <= line_cnt + 1'b1;
                    state    <= line_last ? ST_FRAME_EOL : ST_BYTE_RD;
                end
                ST_FRAME_EOL: begin
                    ret_state <= ST_DONE;
                    state     <= ST_SEND;
                end
                ST_SEND: begin
                    if (char_ready) begin  // valid is high, transfer this cycle
                        state <= ret_state;
                    end
                end
                ST_DONE: state <= ST_DONE;  // left only through abort
                default: state <= ST_IDLE;
            endcase
        end
    end

    // character register, held steady through SEND
    always_ff @(posedge MCLK) begin
        case (state)
            ST_TITLE_LD, ST_PAGE_LD, ST_HI_LD, ST_LO_LD: char_data <= rom_data;
            ST_SPACE:                                    char_data <= `USB_DUMP_SPACE;
            ST_HDR_EOL, ST_LINE_EOL, ST_FRAME_EOL:       char_data <= `USB_DUMP_EOL;
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// ==== src/fifo_write_port.sv ====
`timescale 1ns/1ns
`default_nettype none

module fifo_write_port (
    input  wire                       MCLK,
    input  wire                       reset,
    input  wire                       char_valid,
    input  wire usb_dump_pkg::ascii_t char_data,
    input  wire                       char_abort,
    output logic                      char_ready,
    input  wire                       fifo_txe_n,
    output usb_dump_pkg::ascii_t      fifo_data,
    output logic                      fifo_wr_n
);
    typedef enum logic [1:0] {
        PORT_IDLE,
        PORT_WAIT,
        PORT_STROBE,
        PORT_RELEASE
    } port_state_t;

    port_state_t state;
    logic        strobe_second;  // set in the second low cycle of wr_n

    assign char_ready = (state == PORT_IDLE);

    always_ff @(posedge MCLK) begin
        if (reset) begin
            state         <= PORT_IDLE;
            fifo_wr_n     <= 1'b1;
            strobe_second <= 1'b0;
        end else begin
            case (state)
                PORT_IDLE: begin
                    if (char_valid) begin  // ready is high here, so this is the transfer
                        state <= PORT_WAIT;
                    end
                end
                PORT_WAIT: begin
                    if (char_abort) begin
                        state <= PORT_IDLE;  // character dropped, no strobe
                    end else if (!fifo_txe_n) begin
                        fifo_wr_n     <= 1'b0;
                        strobe_second <= 1'b0;
                        state         <= PORT_STROBE;
                    end
                end
                PORT_STROBE: begin
                    strobe_second <= 1'b1;
                    if (strobe_second) begin
                        fifo_wr_n <= 1'b1;  // two low cycles done
                        state     <= PORT_RELEASE;
                    end
                end
                PORT_RELEASE: begin
                    state <= PORT_IDLE;
                end
                default: begin
                    state <= PORT_IDLE;
                end
            endcase
        end
    end

    // bridge data latch, stable from the cycle after the transfer until the next one
    always_ff @(posedge MCLK) begin
        if (char_valid && char_ready) begin
            fifo_data <= char_data;
        end
    end

endmodule

`default_nettype wire

// ==== src/sipo_buffer.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "usb_dump_cfg.svh"

module sipo_buffer (
    input  wire                           MCLK,
    input  wire                           reset,
    input  wire                           wr_en,
    input  wire usb_dump_pkg::bit_addr_t  wr_addr,
    input  wire                           wr_bit,
    input  wire                           rd_en,
    input  wire usb_dump_pkg::byte_addr_t rd_addr,
    output usb_dump_pkg::ascii_t          rd_data
);
    import usb_dump_pkg::*;

    localparam int DEPTH = 1 << `USB_DUMP_BYTE_ADDR_W;

    ascii_t     mem [DEPTH];  // byte wide page storage
    byte_addr_t wr_byte;
    logic [2:0] wr_pos;

    // bit 8n+k lands in bit k of byte n
    assign wr_byte = wr_addr[`USB_DUMP_BIT_ADDR_W-1:3];
    assign wr_pos  = wr_addr[2:0];

    always_ff @(posedge MCLK) begin
        if (wr_en) begin
            mem[wr_byte][wr_pos] <= wr_bit;  // single bit update
        end
    end

    // registered read, value holds until the next rd_en
    always_ff @(posedge MCLK) begin
        if (reset) begin
            rd_data <= '0;
        end else if (rd_en) begin
            rd_data <= mem[rd_addr];
        end
    end

endmodule

`default_nettype wire

// ==== src/text_rom.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "usb_dump_cfg.svh"

module text_rom (
    input  wire                          MCLK,
    input  wire                          rd_en,
    input  wire usb_dump_pkg::rom_addr_t addr,
    output usb_dump_pkg::ascii_t         data
);
    import usb_dump_pkg::*;

    localparam logic [8*`USB_DUMP_BOOT_LEN-1:0] BOOT_TEXT = `USB_DUMP_BOOT_TITLE;
    localparam logic [8*`USB_DUMP_USER_LEN-1:0] USER_TEXT = `USB_DUMP_USER_TITLE;

    localparam int BOOT_END = `USB_DUMP_BOOT_BASE + `USB_DUMP_BOOT_LEN;
    localparam int USER_END = `USB_DUMP_USER_BASE + `USB_DUMP_USER_LEN;

    // rom contents as a function of the address
    function automatic ascii_t rom_char(input rom_addr_t a);
        int idx;
        idx = int'(a);
        if (idx < 10) begin
            return ascii_t'(8'h30 + idx);  // "0".."9"
        end else if (idx < 16) begin
            return ascii_t'(8'h41 + idx - 10);  // "A".."F"
        end else if (idx >= `USB_DUMP_BOOT_BASE && idx < BOOT_END) begin
            // string literal keeps the first character in the top byte
            return BOOT_TEXT[8*(BOOT_END-1-idx) +: 8];
        end else if (idx >= `USB_DUMP_USER_BASE && idx < USER_END) begin
            return USER_TEXT[8*(USER_END-1-idx) +: 8];
        end
        return `USB_DUMP_SPACE;  // unused locations
    endfunction

    always_ff @(posedge MCLK) begin
        if (rd_en) begin
            data <= rom_char(addr);  // one cycle latency
        end
    end

endmodule

`default_nettype wire

// ==== src/usb_dump_pkg.sv ====
`default_nettype none

`include "usb_dump_cfg.svh"

package usb_dump_pkg;

    typedef logic [7:0]                       ascii_t;      // one character
    typedef logic [`USB_DUMP_BYTE_ADDR_W-1:0] byte_addr_t;  // buffer read side
    typedef logic [`USB_DUMP_BIT_ADDR_W-1:0]  bit_addr_t;   // buffer write side
    typedef logic [`USB_DUMP_ROM_ADDR_W-1:0]  rom_addr_t;
    typedef logic [`USB_DUMP_PAGE_W-1:0]      page_t;

    typedef enum logic [4:0] {
        ST_IDLE,
        ST_TITLE_RD,
        ST_TITLE_LD,
        ST_TITLE_NEXT,
        ST_PAGE_RD,
        ST_PAGE_LD,
        ST_PAGE_NEXT,
        ST_HDR_EOL,
        ST_BYTE_RD,
        ST_HI_RD,
        ST_HI_LD,
        ST_LO_RD,
        ST_LO_LD,
        ST_SPACE,
        ST_BYTE_NEXT,
        ST_LINE_EOL,
        ST_LINE_NEXT,
        ST_FRAME_EOL,
        ST_SEND,
        ST_DONE
    } seq_state_t;

endpackage

`default_nettype wire

// ==== src/usb_dump_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module usb_dump_top (
    input  wire                          MCLK,
    input  wire                          reset,
    input  wire                          buf_wr_en,
    input  wire usb_dump_pkg::bit_addr_t buf_wr_addr,
    input  wire                          buf_wr_bit,
    input  wire                          send_boot,
    input  wire                          send_user,
    input  wire usb_dump_pkg::page_t     page,
    input  wire                          fifo_txe_n,
    output usb_dump_pkg::ascii_t         fifo_data,
    output logic                         fifo_wr_n
);
    import usb_dump_pkg::*;

    wire             buf_rd_en;
    wire byte_addr_t buf_rd_addr;
    wire ascii_t     buf_rd_data;
    wire             rom_rd_en;
    wire rom_addr_t  rom_addr;
    wire ascii_t     rom_data;
    wire             char_valid;
    wire ascii_t     char_data;
    wire             char_abort;
    wire             char_ready;

    sipo_buffer sipo_buffer_i (
        .MCLK    (MCLK),
        .reset   (reset),
        .wr_en   (buf_wr_en),
        .wr_addr (buf_wr_addr),
        .wr_bit  (buf_wr_bit),
        .rd_en   (buf_rd_en),
        .rd_addr (buf_rd_addr),
        .rd_data (buf_rd_data)
    );

    text_rom text_rom_i (
        .MCLK  (MCLK),
        .rd_en (rom_rd_en),
        .addr  (rom_addr),
        .data  (rom_data)
    );

    dump_sequencer dump_sequencer_i (
        .MCLK        (MCLK),
        .reset       (reset),
        .send_boot   (send_boot),
        .send_user   (send_user),
        .page        (page),
        .buf_rd_en   (buf_rd_en),
        .buf_rd_addr (buf_rd_addr),
        .buf_rd_data (buf_rd_data),
        .rom_rd_en   (rom_rd_en),
        .rom_addr    (rom_addr),
        .rom_data    (rom_data),
        .char_valid  (char_valid),
        .char_data   (char_data),
        .char_abort  (char_abort),
        .char_ready  (char_ready)
    );

    fifo_write_port fifo_write_port_i (
        .MCLK       (MCLK),
        .reset      (reset),
        .char_valid (char_valid),
        .char_data  (char_data),
        .char_abort (char_abort),
        .char_ready (char_ready),
        .fifo_txe_n (fifo_txe_n),
        .fifo_data  (fifo_data),
        .fifo_wr_n  (fifo_wr_n)
    );

endmodule

`default_nettype wire

// ==== usb_dump_top.f ====
+incdir+include
src/usb_dump_pkg.sv
src/sipo_buffer.sv
src/text_rom.sv
src/fifo_write_port.sv
src/dump_sequencer.sv
src/usb_dump_top.sv
dv/usb_dump_tb.sv
